// ==== source/board_pkg.sv ====
package board_pkg;

    // serial payload; the step counter reuses it for its count
    typedef logic [7:0] byte_t;

    // one hex digit for a seven-segment display
    typedef logic [3:0] hex_t;

    // segment vector, one bit per segment, active high
    typedef logic [7:0] seg_t;

    // bit positions as the board routes the display pins
    //
    //      a
    //    f   b
    //      g
    //    e   c
    //      d   p
    localparam int SEG_P = 0;
    localparam int SEG_C = 1;
    localparam int SEG_D = 2;
    localparam int SEG_E = 3;
    localparam int SEG_B = 4;
    localparam int SEG_A = 5;
    localparam int SEG_F = 6;
    localparam int SEG_G = 7;

    // board oscillator and the usual console rate
    localparam int DEFAULT_CLK_HZ = 50_000_000;
    localparam int DEFAULT_BAUD   = 115_200;

endpackage

// ==== source/seven_seg_decoder.sv ====
`timescale 1ns/1ps

module seven_seg_decoder (
    input  board_pkg::hex_t hex,
    output board_pkg::seg_t segments
);

    logic [6:0] abcdefg;  // a in the msb

    always_comb begin
        case (hex)
            4'h0: abcdefg = 7'b1111110;
            4'h1: abcdefg = 7'b0110000;
            4'h2: abcdefg = 7'b1101101;
            4'h3: abcdefg = 7'b1111001;
            4'h4: abcdefg = 7'b0110011;
            4'h5: abcdefg = 7'b1011011;
            4'h6: abcdefg = 7'b1011111;
            4'h7: abcdefg = 7'b1110000;
            4'h8: abcdefg = 7'b1111111;
            4'h9: abcdefg = 7'b1111011;
            4'ha: abcdefg = 7'b1110111;
            4'hb: abcdefg = 7'b0011111;  // lower case b
            4'hc: abcdefg = 7'b1001110;
            4'hd: abcdefg = 7'b0111101;  // lower case d
            4'he: abcdefg = 7'b1001111;
            4'hf: abcdefg = 7'b1000111;
            default: abcdefg = 7'b0000000;
        endcase
    end

    // scatter onto the board pin order
    always_comb begin
        segments[board_pkg::SEG_A] = abcdefg[6];
        segments[board_pkg::SEG_B] = abcdefg[5];
        segments[board_pkg::SEG_C] = abcdefg[4];
        segments[board_pkg::SEG_D] = abcdefg[3];
        segments[board_pkg::SEG_E] = abcdefg[2];
        segments[board_pkg::SEG_F] = abcdefg[1];
        segments[board_pkg::SEG_G] = abcdefg[0];
        segments[board_pkg::SEG_P] = 1'b0;  // decimal point off
    end

endmodule

// ==== source/step_counter.sv ====
`timescale 1ns/1ps

module step_counter (
    input  logic              clk_50M,
    input  logic              reset_btn,
    input  logic              clock_btn,
    output board_pkg::byte_t  number,
    output logic [15:0]       leds
);

    logic btn_meta, btn_sync;  // two-flop synchroniser
    logic btn_prev;            // last synchronised level
    logic btn_rise;

    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
        end else begin
            btn_meta <= clock_btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign btn_rise = btn_sync && !btn_prev;

    // one step per press
    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            number <= '0;
            leds   <= 16'h0001;
        end else if (btn_rise) begin
            number <= number + 8'd1;          // wraps past 255
            leds   <= {leds[14:0], leds[15]}; // lit led walks left
        end
    end

endmodule

// ==== source/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver #(
    parameter int CLK_HZ = 50_000_000,
    parameter int BAUD   = 115_200
) (
    input  logic              clk_50M,
    input  logic              reset_btn,
    input  logic              rxd,
    input  logic              rx_ack,
    output logic              rx_req,
    output board_pkg::byte_t  rx_data
);

    localparam int CLKS_PER_BIT = CLK_HZ / BAUD;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta, rx_sync, rx_prev;  // line synchroniser plus edge history
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    board_pkg::byte_t shift;

    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            rx_meta <= 1'b1;  // idle line is high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            rx_req  <= 1'b0;
        end else begin
            if (rx_req && rx_ack)
                rx_req <= 1'b0;  // sink has the byte
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync)
                        state <= RX_START;  // falling edge may be a start bit
                end
                RX_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // a glitch is back high by mid-bit
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == BIT_LAST) begin
                        state <= RX_IDLE;
                        // framing error or a byte still pending drops the frame
                        if (rx_sync && !rx_req && !rx_ack)
                            rx_req <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // payload path with the lsb first
    always_ff @(posedge clk_50M) begin
        if (state == RX_DATA && cnt == BIT_LAST)
            shift <= {rx_sync, shift[7:1]};
        if (state == RX_STOP && cnt == BIT_LAST && rx_sync && !rx_req && !rx_ack)
            rx_data <= shift;
    end

    // request and byte hold until the sink answers
    req_held_until_ack: assert property (
        @(posedge clk_50M) disable iff (reset_btn)
        (rx_req && !rx_ack) |=> (rx_req && $stable(rx_data))
    );

endmodule

// ==== source/echo_fifo.sv ====
`timescale 1ns/1ps

module echo_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk_50M,
    input  logic              reset_btn,
    input  logic              rx_req,
    input  board_pkg::byte_t  rx_data,
    input  logic              tx_ack,
    output logic              rx_ack,
    output logic              tx_req,
    output board_pkg::byte_t  tx_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

    board_pkg::byte_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full, empty;
    logic             push, pop, offer;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign push  = rx_req && !rx_ack && !full;   // sink side takes a byte
    assign pop   = tx_req && tx_ack;             // head has been taken
    assign offer = !tx_req && !tx_ack && !empty; // source side raises req

    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rx_ack <= 1'b0;
            tx_req <= 1'b0;
        end else begin
            // sink handshake
            if (push)
                rx_ack <= 1'b1;
            else if (!rx_req)
                rx_ack <= 1'b0;
            // source handshake
            if (offer)
                tx_req <= 1'b1;
            else if (pop)
                tx_req <= 1'b0;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_50M) begin
        if (push)
            mem[wr_ptr] <= rx_data;
        if (offer)
            tx_data <= mem[rd_ptr];  // held until the transmitter acks
    end

    no_write_when_full: assert property (
        @(posedge clk_50M) disable iff (reset_btn)
        $rose(rx_ack) |-> ($past(count) != FULL_COUNT)
    );

    no_read_when_empty: assert property (
        @(posedge clk_50M) disable iff (reset_btn)
        $fell(tx_req) |-> ($past(count) != '0)
    );

endmodule

// ==== source/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter #(
    parameter int CLK_HZ = 50_000_000,
    parameter int BAUD   = 115_200
) (
    input  logic              clk_50M,
    input  logic              reset_btn,
    input  logic              tx_req,
    input  board_pkg::byte_t  tx_data,
    output logic              tx_ack,
    output logic              txd
);

    localparam int CLKS_PER_BIT = CLK_HZ / BAUD;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bits_left;  // bits still queued after the one on the line
    logic [8:0]       shift;      // data bits then the stop bit
    logic             accept;

    // a fresh request only counts once the previous one was seen low
    assign accept = (state == TX_IDLE) && tx_req && !tx_ack;

    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            state     <= TX_IDLE;
            cnt       <= '0;
            bits_left <= '0;
            tx_ack    <= 1'b0;
            txd       <= 1'b1;
        end else begin
            if (!tx_req)
                tx_ack <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        tx_ack    <= 1'b1;
                        txd       <= 1'b0;  // start bit goes out with the ack
                        cnt       <= '0;
                        bits_left <= 4'd9;
                        state     <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (cnt != BIT_LAST) begin
                        cnt <= cnt + 1'b1;
                    end else if (bits_left == 4'd0) begin
                        state <= TX_IDLE;  // stop bit done, line stays high
                    end else begin
                        cnt       <= '0;
                        txd       <= shift[0];
                        bits_left <= bits_left - 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_50M) begin
        if (accept)
            shift <= {1'b1, tx_data};
        else if (state == TX_SEND && cnt == BIT_LAST)
            shift <= {1'b1, shift[8:1]};
    end

    idle_line_high: assert property (
        @(posedge clk_50M) disable iff (reset_btn)
        (state == TX_IDLE) |-> txd
    );

endmodule

// ==== source/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE    = 800,
    parameter int H_SYNC_START = 856,
    parameter int H_SYNC_END   = 976,
    parameter int H_TOTAL      = 1040,
    parameter int V_VISIBLE    = 600,
    parameter int V_SYNC_START = 637,
    parameter int V_SYNC_END   = 643,
    parameter int V_TOTAL      = 666
) (
    input  logic       clk_50M,
    input  logic       reset_btn,
    output logic       hsync,
    output logic       vsync,
    output logic       data_enable,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [1:0] blue
);

    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);
    localparam logic [H_W-1:0] H_LAST  = H_W'(H_TOTAL - 1);
    localparam logic [V_W-1:0] V_LAST  = V_W'(V_TOTAL - 1);
    localparam logic [H_W-1:0] H_VIS   = H_W'(H_VISIBLE);
    localparam logic [H_W-1:0] H_SS    = H_W'(H_SYNC_START);
    localparam logic [H_W-1:0] H_SE    = H_W'(H_SYNC_END);
    localparam logic [V_W-1:0] V_VIS   = V_W'(V_VISIBLE);
    localparam logic [V_W-1:0] V_SS    = V_W'(V_SYNC_START);
    localparam logic [V_W-1:0] V_SE    = V_W'(V_SYNC_END);
    localparam logic [H_W-1:0] BAR_ONE = H_W'(H_VISIBLE / 3);     // red ends here
    localparam logic [H_W-1:0] BAR_TWO = H_W'(2 * (H_VISIBLE / 3)); // green ends here

    logic [H_W-1:0] hcount;
    logic [V_W-1:0] vcount;
    logic           visible;

    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == H_LAST) begin
            hcount <= '0;
            vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign visible = (hcount < H_VIS) && (vcount < V_VIS);

    // outputs lag the counters by one clock
    always_ff @(posedge clk_50M or posedge reset_btn) begin
        if (reset_btn) begin
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            data_enable <= 1'b0;
            red         <= '0;
            green       <= '0;
            blue        <= '0;
        end else begin
            hsync       <= (hcount >= H_SS) && (hcount < H_SE);  // positive pulse
            vsync       <= (vcount >= V_SS) && (vcount < V_SE);
            data_enable <= visible;
            red         <= {3{visible && (hcount < BAR_ONE)}};
            green       <= {3{visible && (hcount >= BAR_ONE) && (hcount < BAR_TWO)}};
            blue        <= {2{visible && (hcount >= BAR_TWO)}};
        end
    end

endmodule

// ==== source/thinpad_top.sv ====
`timescale 1ns/1ps

module thinpad_top #(
    parameter int CLK_HZ       = board_pkg::DEFAULT_CLK_HZ,
    parameter int BAUD         = board_pkg::DEFAULT_BAUD,
    parameter int FIFO_DEPTH   = 4,
    parameter int H_VISIBLE    = 800,
    parameter int H_SYNC_START = 856,
    parameter int H_SYNC_END   = 976,
    parameter int H_TOTAL      = 1040,
    parameter int V_VISIBLE    = 600,
    parameter int V_SYNC_START = 637,
    parameter int V_SYNC_END   = 643,
    parameter int V_TOTAL      = 666
) (
    input  logic            clk_50M,
    input  logic            reset_btn,
    input  logic            clock_btn,   // manual step button
    input  logic            rxd,
    output logic            txd,
    output logic [15:0]     leds,
    output board_pkg::seg_t dpy0,        // low digit
    output board_pkg::seg_t dpy1,        // high digit
    output logic [2:0]      video_red,
    output logic [2:0]      video_green,
    output logic [1:0]      video_blue,
    output logic            video_hsync,
    output logic            video_vsync,
    output logic            video_clk,
    output logic            video_de
);

    board_pkg::byte_t number;
    logic             rx_req, rx_ack, tx_req, tx_ack;
    board_pkg::byte_t rx_data, tx_data;

    step_counter u_step (
        .clk_50M(clk_50M), .reset_btn(reset_btn), .clock_btn(clock_btn),
        .number(number), .leds(leds)
    );

    seven_seg_decoder u_seg_lo (.hex(number[3:0]), .segments(dpy0));
    seven_seg_decoder u_seg_hi (.hex(number[7:4]), .segments(dpy1));

    // serial echo: receiver, queue, transmitter
    uart_receiver #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) u_rx (
        .clk_50M(clk_50M), .reset_btn(reset_btn), .rxd(rxd),
        .rx_ack(rx_ack), .rx_req(rx_req), .rx_data(rx_data)
    );

    echo_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_50M(clk_50M), .reset_btn(reset_btn),
        .rx_req(rx_req), .rx_data(rx_data), .rx_ack(rx_ack),
        .tx_ack(tx_ack), .tx_req(tx_req), .tx_data(tx_data)
    );

    uart_transmitter #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) u_tx (
        .clk_50M(clk_50M), .reset_btn(reset_btn), .tx_req(tx_req),
        .tx_data(tx_data), .tx_ack(tx_ack), .txd(txd)
    );

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_SYNC_START(H_SYNC_START),
        .H_SYNC_END(H_SYNC_END), .H_TOTAL(H_TOTAL),
        .V_VISIBLE(V_VISIBLE), .V_SYNC_START(V_SYNC_START),
        .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL)
    ) u_video (
        .clk_50M(clk_50M), .reset_btn(reset_btn),
        .hsync(video_hsync), .vsync(video_vsync), .data_enable(video_de),
        .red(video_red), .green(video_green), .blue(video_blue)
    );

    assign video_clk = clk_50M;  // pixel clock is the system clock

endmodule

// ==== verification/tb_thinpad.sv ====
`timescale 1ns/1ps

module tb_thinpad;

    localparam int CLKS_PER_BIT = 10;  // 50 MHz over 5 Mbaud
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int H_TOTAL      = 1040;
    localparam int H_PULSE      = 120;
    localparam int H_VISIBLE    = 800;

    typedef struct packed {
        logic [7:0] data;
        logic       stop_ok;  // drive a high stop bit
        logic       echo;     // a copy is expected on txd
        logic       burst;    // sent back to back with its neighbours
    } frame_t;

    localparam int N_FRAMES = 11;
    localparam frame_t FRAMES [N_FRAMES] = '{
        '{8'h00, 1'b1, 1'b1, 1'b0},
        '{8'hff, 1'b1, 1'b1, 1'b0},
        '{8'h55, 1'b1, 1'b1, 1'b0},
        '{8'ha3, 1'b1, 1'b1, 1'b0},
        '{8'h3c, 1'b0, 1'b0, 1'b0},  // framing error gets dropped
        '{8'h81, 1'b1, 1'b1, 1'b0},
        '{8'h12, 1'b1, 1'b1, 1'b1},
        '{8'h34, 1'b1, 1'b1, 1'b1},
        '{8'hc7, 1'b1, 1'b1, 1'b1},
        '{8'h0f, 1'b1, 1'b1, 1'b1},
        '{8'he9, 1'b1, 1'b1, 1'b1}
    };

    localparam int N_PRESS = 6;
    localparam int PRESSES [N_PRESS] = '{1, 3, 12, 16, 240, 4};  // 276 presses wrap once

    logic        clk_50M, reset_btn, clock_btn, rxd;
    logic        txd;
    logic [15:0] leds;
    logic [7:0]  dpy0, dpy1;
    logic [2:0]  video_red, video_green;
    logic [1:0]  video_blue;
    logic        video_hsync, video_vsync, video_clk, video_de;

    int mismatches;
    int failures;

    thinpad_top #(.BAUD(5_000_000)) UUT (
        .clk_50M(clk_50M), .reset_btn(reset_btn), .clock_btn(clock_btn), .rxd(rxd),
        .txd(txd), .leds(leds), .dpy0(dpy0), .dpy1(dpy1),
        .video_red(video_red), .video_green(video_green), .video_blue(video_blue),
        .video_hsync(video_hsync), .video_vsync(video_vsync),
        .video_clk(video_clk), .video_de(video_de)
    );

    always #10 clk_50M = ~clk_50M;

    // board bit order g f a b e d c p from the msb down
    function automatic logic [7:0] seg_pattern(input logic [3:0] hex);
        case (hex)
            4'h0: return 8'h7e;
            4'h1: return 8'h12;
            4'h2: return 8'hbc;
            4'h3: return 8'hb6;
            4'h4: return 8'hd2;
            4'h5: return 8'he6;
            4'h6: return 8'hee;
            4'h7: return 8'h32;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hfa;
            4'hb: return 8'hce;
            4'hc: return 8'h6c;
            4'hd: return 8'h9e;
            4'he: return 8'hec;
            default: return 8'he8;
        endcase
    endfunction

    // {red, green, blue} for a pixel position within the visible line
    function automatic logic [7:0] bar_colour(input int pos);
        if (pos < 266)
            return 8'b111_000_00;
        else if (pos < 532)
            return 8'b000_111_00;
        return 8'b000_000_11;
    endfunction

    task automatic report_mismatch(input string what, input int got, input int expected);
        mismatches++;
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic press_button(input int times);
        repeat (times) begin
            @(posedge clk_50M);
            #1 clock_btn = 1'b1;
            repeat (4) @(posedge clk_50M);
            #1 clock_btn = 1'b0;
            repeat (4) @(posedge clk_50M);  // covers the 3 cycle update delay
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk_50M);
            #1 rxd = bits[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk_50M);
        end
        if (!stop_bit) begin
            @(posedge clk_50M);
            #1 rxd = 1'b1;  // back to idle
        end
    endtask

    // samples txd at bit centres on the falling clock edge
    task automatic receive_frame(output logic [7:0] data, output bit got_frame);
        int waited;
        waited    = 0;
        got_frame = 1'b0;
        data      = '0;
        @(negedge clk_50M);
        while (txd && waited < 4 * FRAME_CYCLES) begin
            @(negedge clk_50M);
            waited++;
        end
        if (txd) begin
            report_failure("timeout, no start bit appeared on txd");
        end else begin
            got_frame = 1'b1;
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk_50M);
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk_50M);
                data[b] = txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_50M);
            if (txd !== 1'b1)
                report_mismatch("txd stop bit", txd, 1);
        end
    endtask

    task automatic receive_and_compare(input logic [7:0] expected);
        logic [7:0] got;
        bit         got_frame;
        receive_frame(got, got_frame);
        if (got_frame && got !== expected)
            report_mismatch("echoed byte", got, expected);
    endtask

    task automatic expect_silence(input int cycles);
        bit seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge clk_50M);
            if (!txd)
                seen = 1'b1;
        end
        if (seen)
            report_failure("txd sent a start bit after a frame with a bad stop bit");
    endtask

    // pixel clock pin follows the system clock
    task automatic check_video_clock();
        @(posedge clk_50M);
        #5;
        if (video_clk !== 1'b1)
            report_mismatch("video_clk while clk_50M is high", video_clk, 1);
        @(negedge clk_50M);
        #5;
        if (video_clk !== 1'b0)
            report_mismatch("video_clk while clk_50M is low", video_clk, 0);
    endtask

    task automatic check_blank();
        if (!video_de && {video_red, video_green, video_blue} != 8'h00)
            report_mismatch("colour while video_de is low",
                            {video_red, video_green, video_blue}, 0);
    endtask

    task automatic check_video();
        int  waited, high, low, pos;
        logic prev;
        waited = 0;
        high   = 0;
        low    = 0;
        pos    = 0;
        @(negedge clk_50M);
        prev = video_hsync;
        @(negedge clk_50M);
        while (!(video_hsync && !prev) && waited < 2 * H_TOTAL) begin
            prev = video_hsync;
            @(negedge clk_50M);
            waited++;
        end
        if (!(video_hsync && !prev)) begin
            report_failure("timeout, video_hsync never rose");
        end else begin
            while (video_hsync && high < 2 * H_TOTAL) begin
                check_blank();
                high++;
                @(negedge clk_50M);
            end
            while (!video_hsync && low < 2 * H_TOTAL) begin
                check_blank();
                low++;
                @(negedge clk_50M);
            end
            if (high != H_PULSE)
                report_mismatch("hsync pulse length", high, H_PULSE);
            if (high + low != H_TOTAL)
                report_mismatch("hsync period", high + low, H_TOTAL);
        end
        waited = 0;
        while (!video_de && waited < 2 * H_TOTAL) begin
            check_blank();
            @(negedge clk_50M);
            waited++;
        end
        if (!video_de) begin
            report_failure("timeout, video_de never rose");
        end else begin
            // position counts from the rise of data enable
            while (video_de && pos < 2 * H_TOTAL) begin
                if ({video_red, video_green, video_blue} != bar_colour(pos))
                    report_mismatch($sformatf("colour at position %0d", pos),
                                    {video_red, video_green, video_blue}, bar_colour(pos));
                pos++;
                @(negedge clk_50M);
            end
            if (pos != H_VISIBLE)
                report_mismatch("visible line length", pos, H_VISIBLE);
        end
    endtask

    initial begin
        int         total;
        int         i;
        int         first;
        logic [7:0] shown;
        void'($urandom(32'hc54b));
        mismatches = 0;
        failures   = 0;
        total      = 0;
        clk_50M    = 1'b0;
        reset_btn  = 1'b1;
        clock_btn  = 1'b0;
        rxd        = 1'b1;  // idle line

        @(negedge clk_50M);
        if (video_hsync || video_vsync || video_de)
            report_mismatch("video sync in reset", {video_hsync, video_vsync, video_de}, 0);
        repeat (2) @(posedge clk_50M);
        #1 reset_btn = 1'b0;

        @(negedge clk_50M);
        if (leds !== 16'h0001)
            report_mismatch("leds after reset", leds, 16'h0001);
        if (dpy0 !== seg_pattern(4'h0))
            report_mismatch("dpy0 after reset", dpy0, seg_pattern(4'h0));
        if (dpy1 !== seg_pattern(4'h0))
            report_mismatch("dpy1 after reset", dpy1, seg_pattern(4'h0));
        if (txd !== 1'b1)
            report_mismatch("txd after reset", txd, 1);

        check_video_clock();
        check_video();

        for (int p = 0; p < N_PRESS; p++) begin
            press_button(PRESSES[p]);
            total += PRESSES[p];
            shown = 8'(total % 256);
            @(negedge clk_50M);
            if (dpy0 !== seg_pattern(shown[3:0]))
                report_mismatch("dpy0 after presses", dpy0, seg_pattern(shown[3:0]));
            if (dpy1 !== seg_pattern(shown[7:4]))
                report_mismatch("dpy1 after presses", dpy1, seg_pattern(shown[7:4]));
            // with one lit bit a rotate by total mod 16 is a plain shift
            if (leds !== (16'h0001 << (total % 16)))
                report_mismatch("leds after presses", leds, 16'h0001 << (total % 16));
        end

        i = 0;
        while (i < N_FRAMES) begin
            if (FRAMES[i].burst) begin
                first = i;
                while (i < N_FRAMES && FRAMES[i].burst)
                    i++;
                fork
                    for (int k = first; k < i; k++)
                        send_frame(FRAMES[k].data, FRAMES[k].stop_ok);
                    for (int k = first; k < i; k++)
                        receive_and_compare(FRAMES[k].data);
                join
            end else begin
                if (FRAMES[i].echo) begin
                    fork
                        send_frame(FRAMES[i].data, FRAMES[i].stop_ok);
                        receive_and_compare(FRAMES[i].data);
                    join
                end else begin
                    send_frame(FRAMES[i].data, FRAMES[i].stop_ok);
                    expect_silence(3 * FRAME_CYCLES);
                end
                i++;
            end
            repeat (4 + $urandom % 16) @(posedge clk_50M);  // idle gap
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== sim.f ====
source/board_pkg.sv
source/seven_seg_decoder.sv
source/step_counter.sv
source/uart_receiver.sv
source/echo_fifo.sv
source/uart_transmitter.sv
source/video_timing.sv
source/thinpad_top.sv
verification/tb_thinpad.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_thinpad
FILELIST  = sim.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)
